/* logic/spu_pkg.sv */
package spu_pkg;

    // datapath widths
    localparam int DATA_BITS   = 16;
    localparam int SHIFT_BITS  = 4;    // low operand bits used as shift amount

    // channels and flow control
    localparam int NUM_CHAN    = 2;
    localparam int QUEUE_DEPTH = 4;    // also the host's initial command credits
    localparam int RES_CREDITS = 4;    // result credits held by the core at reset

    localparam int LATENCY     = 2;    // issue to result, in cycles

    // derived counter widths
    localparam int PTR_BITS    = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS    = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_BITS = $clog2(RES_CREDITS + 1);

    typedef logic signed [DATA_BITS-1:0] data_t;
    typedef logic                        chan_t;

    typedef enum logic [1:0] {
        OP_SRA  = 2'd0,    // sign-filling shift right
        OP_SRL  = 2'd1,    // zero-filling shift right
        OP_ADD  = 2'd2,    // data + operand, wraps
        OP_PASS = 2'd3     // data unchanged
    } spu_op_e;

    typedef struct packed {
        spu_op_e op;
        data_t   data;
        data_t   operand;
        logic    clear;
    } spu_cmd_t;

    // result of any command with clear set
    localparam data_t CLEAR_DATA = '1;

endpackage

/* logic/spu_issue_if.sv */
`timescale 1ns / 1ps
`default_nettype none

interface spu_issue_if;

    logic              valid;      // one-cycle pulse per command
    spu_pkg::chan_t    chan;
    spu_pkg::spu_op_e  op;
    spu_pkg::data_t    data;
    spu_pkg::data_t    operand;
    logic              clear;

    // arbiter side
    modport src (
        output valid, chan, op, data, operand, clear
    );

    // execution pipeline side, no back-pressure
    modport dst (
        input  valid, chan, op, data, operand, clear
    );

endinterface

`default_nettype wire

/* logic/spu_cmd_queue.sv */
`timescale 1ns / 1ps
`default_nettype none

module spu_cmd_queue (
    input  var logic              clk,
    input  var logic              arst_n,

    input  var logic              cmd_valid,
    input  var spu_pkg::spu_cmd_t cmd,
    output var logic              cmd_credit,   // one pulse per freed entry

    output var logic              not_empty,
    output var spu_pkg::spu_cmd_t head,
    input  var logic              pop
);

    spu_pkg::spu_cmd_t                   mem [spu_pkg::QUEUE_DEPTH];
    logic [spu_pkg::PTR_BITS-1:0]        wr_ptr;
    logic [spu_pkg::PTR_BITS-1:0]        rd_ptr;
    logic [spu_pkg::CNT_BITS-1:0]        count;

    // storage, written whenever the host sends
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            cmd_credit <= pop;              // credit back one cycle after pop
        end
    end

    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

endmodule

`default_nettype wire

/* logic/spu_issue_arbiter.sv */
`timescale 1ns / 1ps
`default_nettype none

module spu_issue_arbiter (
    input  var logic              clk,
    input  var logic              arst_n,

    input  var logic              not_empty [spu_pkg::NUM_CHAN],
    input  var spu_pkg::spu_cmd_t head      [spu_pkg::NUM_CHAN],
    output var logic              pop       [spu_pkg::NUM_CHAN],

    input  var logic              res_credit,   // host returned one result slot
    spu_issue_if.src              issue
);

    logic [spu_pkg::CREDIT_BITS-1:0] credit_cnt;
    spu_pkg::chan_t                  last_grant;
    spu_pkg::chan_t                  cand;
    spu_pkg::chan_t                  grant_chan;
    logic                            grant_any;
    logic                            grant_fire;

    // round robin, search starts just after the last winner
    always_comb begin
        grant_any  = 1'b0;
        grant_chan = last_grant;
        cand       = last_grant;
        for (int i = 1; i <= spu_pkg::NUM_CHAN; i++) begin
            cand = last_grant + spu_pkg::chan_t'(i);
            if (!grant_any && not_empty[cand]) begin
                grant_any  = 1'b1;
                grant_chan = cand;
            end
        end
    end

    assign grant_fire = grant_any && (credit_cnt != '0);   // never issue without credit

    always_comb begin
        for (int c = 0; c < spu_pkg::NUM_CHAN; c++) begin
            pop[c] = grant_fire && (grant_chan == spu_pkg::chan_t'(c));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt  <= spu_pkg::CREDIT_BITS'(spu_pkg::RES_CREDITS);
            last_grant  <= '0;
            issue.valid <= 1'b0;
        end else begin
            case ({grant_fire, res_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;      // both or neither
            endcase
            if (grant_fire) begin
                last_grant <= grant_chan;
            end
            issue.valid <= grant_fire;
        end
    end

    // issue payload
    always_ff @(posedge clk) begin
        if (grant_fire) begin
            issue.chan    <= grant_chan;
            issue.op      <= head[grant_chan].op;
            issue.data    <= head[grant_chan].data;
            issue.operand <= head[grant_chan].operand;
            issue.clear   <= head[grant_chan].clear;
        end
    end

endmodule

`default_nettype wire

/* logic/spu_op_delay.sv */
`timescale 1ns / 1ps
`default_nettype none

module spu_op_delay (
    input  var logic            clk,
    input  var logic            arst_n,

    input  var logic            s_valid,
    input  var logic            s_clear,
    input  var spu_pkg::chan_t  s_chan,
    input  var spu_pkg::data_t  s_data,

    output var logic            m_valid,
    output var spu_pkg::chan_t  m_chan,
    output var spu_pkg::data_t  m_data
);

    logic           valid_q [spu_pkg::LATENCY];
    logic           clear_q [spu_pkg::LATENCY];
    spu_pkg::chan_t chan_q  [spu_pkg::LATENCY];
    spu_pkg::data_t data_q  [spu_pkg::LATENCY];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < spu_pkg::LATENCY; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= s_valid;
            for (int i = 1; i < spu_pkg::LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // clear travels alongside the data
    always_ff @(posedge clk) begin
        clear_q[0] <= s_clear;
        chan_q[0]  <= s_chan;
        data_q[0]  <= s_data;
        for (int i = 1; i < spu_pkg::LATENCY; i++) begin
            clear_q[i] <= clear_q[i-1];
            chan_q[i]  <= chan_q[i-1];
            data_q[i]  <= data_q[i-1];
        end
    end

    assign m_valid = valid_q[spu_pkg::LATENCY-1];
    assign m_chan  = chan_q[spu_pkg::LATENCY-1];
    assign m_data  = clear_q[spu_pkg::LATENCY-1] ? spu_pkg::CLEAR_DATA
                                                 : data_q[spu_pkg::LATENCY-1];

endmodule

`default_nettype wire

/* logic/spu_op_sra.sv */
`timescale 1ns / 1ps
`default_nettype none

module spu_op_sra (
    input  var logic                          clk,
    input  var logic                          arst_n,

    input  var logic                          s_valid,
    input  var logic                          s_clear,
    input  var spu_pkg::chan_t                s_chan,
    input  var spu_pkg::data_t                s_data,
    input  var logic [spu_pkg::SHIFT_BITS-1:0] s_shift,
    input  var logic                          s_arith,    // 1: sign fill, 0: zero fill

    output var logic                          m_valid,
    output var spu_pkg::chan_t                m_chan,
    output var spu_pkg::data_t                m_data
);

    spu_pkg::data_t st0_data;

    // combinational shift ahead of the latency pipe
    assign st0_data = s_arith ? (s_data >>> s_shift)
                              : spu_pkg::data_t'($unsigned(s_data) >> s_shift);

    spu_op_delay u_latency (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_clear (s_clear),
        .s_chan  (s_chan),
        .s_data  (st0_data),
        .m_valid (m_valid),
        .m_chan  (m_chan),
        .m_data  (m_data)
    );

endmodule

`default_nettype wire

/* logic/spu_exec.sv */
`timescale 1ns / 1ps
`default_nettype none

module spu_exec (
    input  var logic            clk,
    input  var logic            arst_n,
    spu_issue_if.dst            issue,

    output var logic            res_valid,
    output var spu_pkg::chan_t  res_chan,
    output var spu_pkg::data_t  res_data
);

    logic           is_shift;
    spu_pkg::data_t alu_data;
    logic           sra_valid;
    spu_pkg::chan_t sra_chan;
    spu_pkg::data_t sra_data;
    logic           dly_valid;
    spu_pkg::chan_t dly_chan;
    spu_pkg::data_t dly_data;

    assign is_shift = (issue.op == spu_pkg::OP_SRA) || (issue.op == spu_pkg::OP_SRL);

    // add wraps at DATA_BITS
    assign alu_data = (issue.op == spu_pkg::OP_ADD) ? issue.data + issue.operand
                                                    : issue.data;

    spu_op_sra u_shift (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (issue.valid && is_shift),
        .s_clear (issue.clear),
        .s_chan  (issue.chan),
        .s_data  (issue.data),
        .s_shift (issue.operand[spu_pkg::SHIFT_BITS-1:0]),
        .s_arith (issue.op == spu_pkg::OP_SRA),
        .m_valid (sra_valid),
        .m_chan  (sra_chan),
        .m_data  (sra_data)
    );

    spu_op_delay u_alu_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (issue.valid && !is_shift),
        .s_clear (issue.clear),
        .s_chan  (issue.chan),
        .s_data  (alu_data),
        .m_valid (dly_valid),
        .m_chan  (dly_chan),
        .m_data  (dly_data)
    );

    // equal latency on both paths, at most one valid per cycle
    assign res_valid = sra_valid || dly_valid;
    assign res_chan  = sra_valid ? sra_chan : dly_chan;
    assign res_data  = sra_valid ? sra_data : dly_data;

endmodule

`default_nettype wire

/* logic/spu_core.sv */
`timescale 1ns / 1ps
`default_nettype none

module spu_core (
    input  var logic                          clk,
    input  var logic                          arst_n,

    // command side, one lane per channel
    input  var logic [spu_pkg::NUM_CHAN-1:0]  cmd_valid,
    input  var spu_pkg::spu_op_e              cmd_op      [spu_pkg::NUM_CHAN],
    input  var spu_pkg::data_t                cmd_data    [spu_pkg::NUM_CHAN],
    input  var spu_pkg::data_t                cmd_operand [spu_pkg::NUM_CHAN],
    input  var logic [spu_pkg::NUM_CHAN-1:0]  cmd_clear,
    output var logic [spu_pkg::NUM_CHAN-1:0]  cmd_credit,

    // result side
    output var logic                          res_valid,
    output var spu_pkg::chan_t                res_chan,
    output var spu_pkg::data_t                res_data,
    input  var logic                          res_credit
);

    spu_pkg::spu_cmd_t cmd       [spu_pkg::NUM_CHAN];
    logic              not_empty [spu_pkg::NUM_CHAN];
    spu_pkg::spu_cmd_t head      [spu_pkg::NUM_CHAN];
    logic              pop       [spu_pkg::NUM_CHAN];

    spu_issue_if issue_bus ();

    for (genvar c = 0; c < spu_pkg::NUM_CHAN; c++) begin : g_chan
        assign cmd[c] = '{
            op:      cmd_op[c],
            data:    cmd_data[c],
            operand: cmd_operand[c],
            clear:   cmd_clear[c]
        };

        spu_cmd_queue u_queue (
            .clk        (clk),
            .arst_n     (arst_n),
            .cmd_valid  (cmd_valid[c]),
            .cmd        (cmd[c]),
            .cmd_credit (cmd_credit[c]),
            .not_empty  (not_empty[c]),
            .head       (head[c]),
            .pop        (pop[c])
        );
    end

    spu_issue_arbiter u_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .not_empty  (not_empty),
        .head       (head),
        .pop        (pop),
        .res_credit (res_credit),
        .issue      (issue_bus.src)
    );

    spu_exec u_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue_bus.dst),
        .res_valid (res_valid),
        .res_chan  (res_chan),
        .res_data  (res_data)
    );

endmodule

`default_nettype wire

/* dv/spu_clk_gen.sv */
`timescale 1ns/1ps

module spu_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;    // 8 ns period
        end
    end

endmodule

/* dv/spu_core_sva.sv */
`timescale 1ns/1ps

module spu_core_sva (
    input logic                              clk,
    input logic                              arst_n,
    input logic [spu_pkg::NUM_CHAN-1:0]      cmd_valid,
    input logic [spu_pkg::NUM_CHAN-1:0]      cmd_credit,
    input logic                              res_valid,
    input logic                              res_credit,
    input logic                              issue_valid,
    input logic                              grant_fire,
    input logic [spu_pkg::CNT_BITS-1:0]      q0_count,
    input logic [spu_pkg::CNT_BITS-1:0]      q1_count
);

    logic                            seen_cmd;    // any command accepted since reset
    logic [spu_pkg::CREDIT_BITS-1:0] in_use;      // issued, result credit not yet back

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seen_cmd <= 1'b0;
        end else if (cmd_valid != '0) begin
            seen_cmd <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_use <= '0;
        end else begin
            in_use <= in_use + spu_pkg::CREDIT_BITS'(grant_fire)
                             - spu_pkg::CREDIT_BITS'(res_credit);
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_cmd |-> (!res_valid && cmd_credit == '0))
        else $error("result or command credit seen before any command");

    no_write_full_q0: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_valid[0] |-> (q0_count < spu_pkg::CNT_BITS'(spu_pkg::QUEUE_DEPTH)))
        else $error("queue 0 written while full");

    no_write_full_q1: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_valid[1] |-> (q1_count < spu_pkg::CNT_BITS'(spu_pkg::QUEUE_DEPTH)))
        else $error("queue 1 written while full");

    no_issue_without_credit: assert property (@(posedge clk) disable iff (!arst_n)
        grant_fire |-> (in_use < spu_pkg::CREDIT_BITS'(spu_pkg::RES_CREDITS)))
        else $error("issue with zero result credits");

    // both directions at once
    fixed_latency: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid == $past(issue_valid, spu_pkg::LATENCY))
        else $error("res_valid not LATENCY cycles after issue");

endmodule

/* dv/spu_tb.sv */
`timescale 1ns/1ps

module spu_tb;

    logic                         clk;
    logic                         arst_n;
    logic [spu_pkg::NUM_CHAN-1:0] cmd_valid;
    spu_pkg::spu_op_e             cmd_op      [spu_pkg::NUM_CHAN];
    spu_pkg::data_t               cmd_data    [spu_pkg::NUM_CHAN];
    spu_pkg::data_t               cmd_operand [spu_pkg::NUM_CHAN];
    logic [spu_pkg::NUM_CHAN-1:0] cmd_clear;
    logic [spu_pkg::NUM_CHAN-1:0] cmd_credit;
    logic                         res_valid;
    spu_pkg::chan_t               res_chan;
    spu_pkg::data_t               res_data;
    logic                         res_credit;

    spu_pkg::spu_cmd_t send_q [spu_pkg::NUM_CHAN][$];
    spu_pkg::data_t    exp_q  [spu_pkg::NUM_CHAN][$];
    spu_pkg::chan_t    issue_order [$];   // one entry per credit pulse
    int                host_credits [spu_pkg::NUM_CHAN];
    int                sent [spu_pkg::NUM_CHAN];
    int                seen [spu_pkg::NUM_CHAN];
    int                total_cmds;
    int                total_seen;
    int                credit_pulses;
    int                held_results;     // consumed, credit not yet returned
    int                hold_cycles;
    int                cycles;

    spu_clk_gen u_clk (.clk(clk));

    spu_core dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_data    (cmd_data),
        .cmd_operand (cmd_operand),
        .cmd_clear   (cmd_clear),
        .cmd_credit  (cmd_credit),
        .res_valid   (res_valid),
        .res_chan    (res_chan),
        .res_data    (res_data),
        .res_credit  (res_credit)
    );

    bind spu_core spu_core_sva u_sva (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd_credit  (cmd_credit),
        .res_valid   (res_valid),
        .res_credit  (res_credit),
        .issue_valid (issue_bus.valid),
        .grant_fire  (u_arbiter.grant_fire),
        .q0_count    (g_chan[0].u_queue.count),
        .q1_count    (g_chan[1].u_queue.count)
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input spu_pkg::data_t got, input spu_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t: %s data %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_chan(input spu_pkg::chan_t got, input spu_pkg::chan_t exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t: %s channel %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic load_stimulus();
        int                fd;
        int                n;
        string             line;
        logic [31:0]       f_chan;
        logic [31:0]       f_op;
        logic [31:0]       f_data;
        logic [31:0]       f_operand;
        logic [31:0]       f_clear;
        logic [31:0]       f_expected;
        spu_pkg::spu_cmd_t cmd;
        fd = $fopen("dv/spu_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the stimulus file dv/spu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h", f_chan, f_op, f_data, f_operand,
                            f_clear, f_expected);
                if (n == 6) begin    // comment and blank lines fall through
                    cmd.op      = spu_pkg::spu_op_e'(f_op[1:0]);
                    cmd.data    = spu_pkg::data_t'(f_data[15:0]);
                    cmd.operand = spu_pkg::data_t'(f_operand[15:0]);
                    cmd.clear   = f_clear[0];
                    send_q[f_chan[0]].push_back(cmd);
                    exp_q[f_chan[0]].push_back(spu_pkg::data_t'(f_expected[15:0]));
                    total_cmds++;
                end
            end
            $fclose(fd);
        end
    endtask

    // mostly short holds, now and then a long stall
    function automatic int pick_hold();
        if (($urandom % 6) == 0) begin
            return 12 + int'($urandom % 12);
        end
        return int'($urandom % 3);
    endfunction

    task automatic collect_outputs();
        spu_pkg::chan_t exp_chan;
        spu_pkg::data_t exp_data;
        for (int c = 0; c < spu_pkg::NUM_CHAN; c++) begin
            if (cmd_credit[c]) begin
                host_credits[c]++;
                credit_pulses++;
                issue_order.push_back(spu_pkg::chan_t'(c));    // pop order is issue order
                if (host_credits[c] > spu_pkg::QUEUE_DEPTH) begin
                    stop_run($sformatf("channel %0d returned more command credits than sent", c));
                end
            end
        end
        if (res_valid) begin
            if (issue_order.size() == 0) begin
                stop_run("result arrived with no command taken from a queue");
            end else begin
                exp_chan = issue_order.pop_front();
                check_chan(res_chan, exp_chan, $sformatf("result %0d", total_seen));
                if (seen[res_chan] >= sent[res_chan] || exp_q[res_chan].size() == 0) begin
                    stop_run($sformatf("result on channel %0d with no command in flight",
                                       res_chan));
                end else begin
                    exp_data = exp_q[res_chan].pop_front();
                    check_data(res_data, exp_data, $sformatf("result %0d", total_seen));
                    seen[res_chan]++;
                    total_seen++;
                    held_results++;
                    if (held_results > spu_pkg::RES_CREDITS) begin
                        stop_run("more results arrived than the result credits allow");
                    end
                end
            end
        end
    endtask

    task automatic return_result_credit();
        res_credit = 1'b0;
        if (held_results > 0) begin
            if (hold_cycles > 0) begin
                hold_cycles--;
            end else begin
                res_credit   = 1'b1;    // one pulse per consumed result
                held_results--;
                hold_cycles  = pick_hold();
            end
        end
    endtask

    task automatic send_commands();
        spu_pkg::spu_cmd_t cmd;
        for (int c = 0; c < spu_pkg::NUM_CHAN; c++) begin
            cmd_valid[c] = 1'b0;
            if (host_credits[c] > 0 && send_q[c].size() > 0 && ($urandom % 4) != 0) begin
                cmd            = send_q[c].pop_front();
                cmd_valid[c]   = 1'b1;
                cmd_op[c]      = cmd.op;
                cmd_data[c]    = cmd.data;
                cmd_operand[c] = cmd.operand;
                cmd_clear[c]   = cmd.clear;
                host_credits[c]--;
                sent[c]++;
            end
        end
    endtask

    initial begin
        void'($urandom(74));
        arst_n     = 1'b0;
        cmd_valid  = '0;
        cmd_clear  = '0;
        res_credit = 1'b0;
        for (int c = 0; c < spu_pkg::NUM_CHAN; c++) begin
            cmd_op[c]       = spu_pkg::OP_PASS;
            cmd_data[c]     = '0;
            cmd_operand[c]  = '0;
            host_credits[c] = spu_pkg::QUEUE_DEPTH;
            sent[c]         = 0;
            seen[c]         = 0;
        end
        total_cmds    = 0;
        total_seen    = 0;
        credit_pulses = 0;
        held_results  = 0;
        hold_cycles   = 0;
        load_stimulus();

        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        cycles = 0;
        while (total_seen < total_cmds) begin
            @(negedge clk);
            collect_outputs();
            return_result_credit();
            send_commands();
            cycles++;
            if (cycles > 5000) begin
                stop_run("timed out waiting for all results");
            end
        end

        // remaining command credits should already be back
        cycles = 0;
        while (credit_pulses < total_cmds) begin
            @(negedge clk);
            collect_outputs();
            return_result_credit();
            send_commands();
            cycles++;
            if (cycles > 20) begin
                stop_run("timed out waiting for command credits to return");
            end
        end

        if (credit_pulses != total_cmds) begin
            stop_run("command credit count does not match commands sent");
        end else if (exp_q[0].size() != 0 || exp_q[1].size() != 0 ||
                     issue_order.size() != 0) begin
            stop_run("expected results left over at the end of the run");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* files.f */
logic/spu_pkg.sv
logic/spu_issue_if.sv
logic/spu_cmd_queue.sv
logic/spu_issue_arbiter.sv
logic/spu_op_delay.sv
logic/spu_op_sra.sv
logic/spu_exec.sv
logic/spu_core.sv
dv/spu_clk_gen.sv
dv/spu_core_sva.sv
dv/spu_tb.sv

/* Makefile */
TOP = spu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) > run.log 2>&1
	@cat run.log
	@if grep -q "Done: errors found" run.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" run.log || { echo "simulation did not finish"; exit 1; }

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

/* dv/spu_stimulus.txt */
# columns (hex): channel opcode data operand clear expected
# opcode 0 sra, 1 srl, 2 add, 3 pass
0 0 8000 0004 0 f800
1 0 8000 0004 0 f800
0 1 8000 0004 0 0800
1 1 f0f0 0008 0 00f0
0 2 7fff 0001 0 8000
1 2 ffff 0002 0 0001
0 3 1234 0000 0 1234
1 3 abcd 5555 0 abcd
0 0 1234 0000 1 ffff
1 2 0001 0001 1 ffff
0 0 7ff0 0014 0 07ff
1 0 ffff 000f 0 ffff
0 1 ffff 000f 0 0001
1 1 8001 0001 0 4000
0 2 1234 1111 0 2345
1 2 8000 8000 0 0000
0 3 0000 ffff 0 0000
1 3 5a5a 0000 1 ffff
0 1 c000 0002 1 ffff
1 0 c000 0002 0 f000
0 0 4000 0003 0 0800
1 1 4000 0003 0 0800
0 2 00ff 0001 0 0100
1 3 0f0f 00ff 0 0f0f
0 1 1234 0000 0 1234
1 0 9000 0001 0 c800
0 2 fff0 0010 0 0000
1 2 0003 fffe 0 0001
